/* all.f */
src/video_pkg.sv
src/detect_pkg.sv
src/convolution_filter.sv
src/frame_capture.sv
src/white_analyzer.sv
src/pattern_recognition.sv
test/pattern_recognition_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f \
    --top-module pattern_recognition_tb -o pattern_recognition_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/pattern_recognition_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* src/convolution_filter.sv */
`timescale 1ns/1ns

module convolution_filter #(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 6
) (
    input  logic              clk_video,
    input  logic              rst_n,
    input  logic              x_valid,
    output logic              x_ready,
    input  video_pkg::pixel_t x_data,
    input  video_pkg::coef_t  kernel [0:video_pkg::KERNEL_SIZE-1][0:video_pkg::KERNEL_SIZE-1],
    output logic              y_valid,
    input  logic              y_ready,
    output video_pkg::pixel_t y_data
);

    localparam int K     = video_pkg::KERNEL_SIZE;
    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

    video_pkg::pixel_t line0 [0:IMG_WIDTH-1];  // Previous row
    video_pkg::pixel_t line1 [0:IMG_WIDTH-1];  // Row before that
    video_pkg::pixel_t win [0:K-1][0:K-1];     // [row][col], [0][0] is top-left

    logic [COL_W-1:0]                    col;
    logic [ROW_W-1:0]                    row;
    logic                                active;     // Low only until first edge after reset
    logic                                stall;
    logic                                x_fire;
    logic                                win_valid;  // Stage 1, window complete
    logic signed [video_pkg::ACC_W-1:0]  acc_next;
    logic signed [video_pkg::ACC_W-1:0]  acc;        // Stage 2, MAC result
    logic                                acc_valid;
    video_pkg::pixel_t                   y_next;

    // Whole pipe freezes while output waits on the sink
    assign stall   = y_valid && !y_ready;
    assign x_ready = active && !stall;
    assign x_fire  = x_valid && x_ready;

    // ======================================
    // Line buffers and window
    // ======================================
    always_ff @(posedge clk_video) begin
        if (x_fire) begin
            line1[col] <= line0[col];  // Age the column by one row
            line0[col] <= x_data;
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win[r][c] <= win[r][c+1];  // Shift left
                end
            end
            win[0][K-1] <= line1[col];
            win[1][K-1] <= line0[col];
            win[2][K-1] <= x_data;       // Newest pixel enters bottom-right
        end
    end

    // Position counters and valid pipe
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            col       <= '0;
            row       <= '0;
            win_valid <= 1'b0;
            acc_valid <= 1'b0;
            y_valid   <= 1'b0;
        end else begin
            active <= 1'b1;
            if (x_fire) begin
                if (col == COL_W'(IMG_WIDTH - 1)) begin
                    col <= '0;
                    // Wrap at end of frame
                    row <= (row == ROW_W'(IMG_HEIGHT - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            if (!stall) begin
                win_valid <= x_fire && (row >= ROW_W'(K - 1)) && (col >= COL_W'(K - 1));
                acc_valid <= win_valid;
                y_valid   <= acc_valid;
            end
        end
    end

    // ======================================
    // Multiply-accumulate and clamp
    // ======================================
    always_comb begin
        acc_next = '0;
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                // Pixel zero-extended so it stays positive
                acc_next = acc_next + kernel[r][c] * $signed({1'b0, win[r][c]});
            end
        end
    end

    always_comb begin
        if (acc < 0) begin
            y_next = '0;
        end else if (acc > 255) begin
            y_next = 8'd255;       // Saturate high
        end else begin
            y_next = acc[7:0];
        end
    end

    // Data registers, advance with the valid pipe
    always_ff @(posedge clk_video) begin
        if (!stall) begin
            if (win_valid) acc <= acc_next;
            if (acc_valid) y_data <= y_next;
        end
    end

endmodule

/* src/detect_pkg.sv */
package detect_pkg;

    // ======================================
    // Analyzer result widths
    // ======================================

    // White pixel count and the area limits
    localparam int COUNT_W = 16;

    // Horizontal segment count
    localparam int SEG_W = 8;

    // ======================================
    // Defaults
    // ======================================

    // Mid grey splits white from dark
    localparam int DEF_WHITE_THRESHOLD = 128;

endpackage

/* src/frame_capture.sv */
`timescale 1ns/1ns

module frame_capture #(
    parameter  int IMG_WIDTH    = 8,
    parameter  int IMG_HEIGHT   = 6,
    localparam int FRAME_PIXELS = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2),
    localparam int ADDR_W       = $clog2(FRAME_PIXELS)
) (
    input  logic              clk_video,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              in_ready,
    input  video_pkg::pixel_t in_data,
    input  logic              capture_trigger,
    output logic              capturing,
    output logic              capture_complete,
    input  logic [ADDR_W-1:0] rd_addr,
    output video_pkg::pixel_t rd_data
);

    localparam logic ST_IDLE  = 1'b0;
    localparam logic ST_ARMED = 1'b1;

    video_pkg::pixel_t mem [0:FRAME_PIXELS-1];  // One filtered frame

    logic              state;
    logic [ADDR_W-1:0] wr_addr;
    logic              wr_fire;

    assign capturing = (state == ST_ARMED);
    assign wr_fire   = capturing && in_valid && in_ready;  // Only sampled transfers

    // ======================================
    // Capture control
    // ======================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            state            <= ST_IDLE;
            wr_addr          <= '0;
            capture_complete <= 1'b0;
        end else begin
            capture_complete <= 1'b0;  // Single-cycle pulse
            case (state)
                ST_IDLE: begin
                    if (capture_trigger) begin
                        state   <= ST_ARMED;
                        wr_addr <= '0;   // Next transfer lands at 0
                    end
                end
                ST_ARMED: begin
                    // Triggers here are ignored
                    if (wr_fire) begin
                        if (wr_addr == ADDR_W'(FRAME_PIXELS - 1)) begin
                            state            <= ST_IDLE;
                            capture_complete <= 1'b1;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Frame memory with one write port and a registered read port
    always_ff @(posedge clk_video) begin
        if (wr_fire) mem[wr_addr] <= in_data;
        rd_data <= mem[rd_addr];  // Data one cycle after address
    end

endmodule

/* src/pattern_recognition.sv */
`timescale 1ns/1ns

module pattern_recognition #(
    parameter int IMG_WIDTH       = 8,
    parameter int IMG_HEIGHT      = 6,
    parameter int WHITE_THRESHOLD = detect_pkg::DEF_WHITE_THRESHOLD,
    parameter int MIN_AREA        = 4,
    parameter int MAX_AREA        = 20,
    parameter int MIN_SEGMENTS    = 2
) (
    input  logic                           clk_video,
    input  logic                           rst_n,
    input  logic                           x_valid,   // Raw pixel stream
    output logic                           x_ready,
    input  video_pkg::pixel_t              x_data,
    input  video_pkg::coef_t               kernel [0:video_pkg::KERNEL_SIZE-1]
                                                  [0:video_pkg::KERNEL_SIZE-1],
    output logic                           y_valid,   // Filtered stream
    input  logic                           y_ready,
    output video_pkg::pixel_t              y_data,
    input  logic                           capture_trigger,
    output logic                           capture_complete,
    output logic                           capturing,
    output logic                           crossing_detected,
    output logic                           detection_valid,
    output logic [detect_pkg::COUNT_W-1:0] white_count,
    output logic [detect_pkg::SEG_W-1:0]   segment_count
);

    localparam int ADDR_W = $clog2((IMG_WIDTH - 2) * (IMG_HEIGHT - 2));

    logic [ADDR_W-1:0] rd_addr;
    video_pkg::pixel_t rd_data;
    logic              analysis_start;

    // ======================================
    // Filter
    // ======================================
    convolution_filter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) filter_i (
        .clk_video, .rst_n,
        .x_valid, .x_ready, .x_data,
        .kernel,
        .y_valid, .y_ready, .y_data
    );

    // Capture taps the output stream and follows the sink's ready
    frame_capture #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) capture_i (
        .clk_video, .rst_n,
        .in_valid         (y_valid),
        .in_ready         (y_ready),
        .in_data          (y_data),
        .capture_trigger, .capturing, .capture_complete,
        .rd_addr, .rd_data
    );

    // Kick the analyzer one cycle after the frame lands
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            analysis_start <= 1'b0;
        end else begin
            analysis_start <= capture_complete;
        end
    end

    white_analyzer #(
        .IMG_WIDTH       (IMG_WIDTH),
        .IMG_HEIGHT      (IMG_HEIGHT),
        .WHITE_THRESHOLD (WHITE_THRESHOLD),
        .MIN_AREA        (MIN_AREA),
        .MAX_AREA        (MAX_AREA),
        .MIN_SEGMENTS    (MIN_SEGMENTS)
    ) analyzer_i (
        .clk_video, .rst_n,
        .start (analysis_start),
        .rd_addr, .rd_data,
        .white_count, .segment_count,
        .crossing_detected, .detection_valid
    );

endmodule

/* src/video_pkg.sv */
package video_pkg;

    // ======================================
    // Pixel and kernel words
    // ======================================

    // Unsigned grey level, 0 black, 255 white
    typedef logic [7:0] pixel_t;

    // Signed kernel tap
    typedef logic signed [7:0] coef_t;

    // ======================================
    // Filter geometry
    // ======================================

    // Window side, the filter is built as a fixed 3x3 structure
    localparam int KERNEL_SIZE = 3;

    // Sum of nine 8b x 9b products, worst case about +-294k
    localparam int ACC_W = 20;

endpackage

/* src/white_analyzer.sv */
`timescale 1ns/1ns

module white_analyzer #(
    parameter  int IMG_WIDTH       = 8,
    parameter  int IMG_HEIGHT      = 6,
    parameter  int WHITE_THRESHOLD = detect_pkg::DEF_WHITE_THRESHOLD,
    parameter  int MIN_AREA        = 4,
    parameter  int MAX_AREA        = 20,
    parameter  int MIN_SEGMENTS    = 2,
    localparam int FRAME_W         = IMG_WIDTH - 2,
    localparam int FRAME_PIXELS    = FRAME_W * (IMG_HEIGHT - 2),
    localparam int ADDR_W          = $clog2(FRAME_PIXELS),
    localparam int COL_W           = $clog2(FRAME_W)
) (
    input  logic                         clk_video,
    input  logic                         rst_n,
    input  logic                         start,
    output logic [ADDR_W-1:0]            rd_addr,
    input  video_pkg::pixel_t            rd_data,
    output logic [detect_pkg::COUNT_W-1:0] white_count,
    output logic [detect_pkg::SEG_W-1:0]   segment_count,
    output logic                         crossing_detected,
    output logic                         detection_valid
);

    logic                           scanning;    // Address phase
    logic [COL_W-1:0]               col;         // Column of rd_addr
    logic                           d_valid;     // rd_data holds a frame pixel
    logic [COL_W-1:0]               d_col;       // Column of rd_data
    logic                           d_last;
    logic                           done;
    logic                           prev_white;
    logic                           is_white;
    logic [detect_pkg::COUNT_W-1:0] white_acc;
    logic [detect_pkg::SEG_W-1:0]   seg_acc;

    assign is_white = (rd_data >= video_pkg::pixel_t'(WHITE_THRESHOLD));

    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            scanning          <= 1'b0;
            rd_addr           <= '0;
            col               <= '0;
            d_valid           <= 1'b0;
            d_col             <= '0;
            d_last            <= 1'b0;
            done              <= 1'b0;
            prev_white        <= 1'b0;
            white_acc         <= '0;
            seg_acc           <= '0;
            white_count       <= '0;
            segment_count     <= '0;
            crossing_detected <= 1'b0;
            detection_valid   <= 1'b0;
        end else begin
            detection_valid <= 1'b0;
            // ======================================
            // Address walk
            // ======================================
            if (start) begin
                scanning  <= 1'b1;
                rd_addr   <= '0;
                col       <= '0;
                white_acc <= '0;
                seg_acc   <= '0;
            end else if (scanning) begin
                if (rd_addr == ADDR_W'(FRAME_PIXELS - 1)) scanning <= 1'b0;
                rd_addr <= rd_addr + 1'b1;
                col     <= (col == COL_W'(FRAME_W - 1)) ? '0 : col + 1'b1;
            end
            // Delay tags to line up with rd_data
            d_valid <= scanning;
            d_col   <= col;
            d_last  <= scanning && (rd_addr == ADDR_W'(FRAME_PIXELS - 1));
            // ======================================
            // Pixel classification
            // ======================================
            if (d_valid) begin
                prev_white <= is_white;
                if (is_white) begin
                    white_acc <= white_acc + 1'b1;
                    // New run at row start or after dark pixel
                    if (!prev_white || d_col == '0) seg_acc <= seg_acc + 1'b1;
                end
            end
            done <= d_valid && d_last;
            if (done) begin
                white_count       <= white_acc;
                segment_count     <= seg_acc;
                crossing_detected <= (white_acc >= detect_pkg::COUNT_W'(MIN_AREA))
                                  && (white_acc <= detect_pkg::COUNT_W'(MAX_AREA))
                                  && (seg_acc >= detect_pkg::SEG_W'(MIN_SEGMENTS));
                detection_valid   <= 1'b1;
            end
        end
    end

endmodule

/* test/pattern_recognition_tb.sv */
`timescale 1ns/1ns

module pattern_recognition_tb;

    localparam int IMG_W      = 8;
    localparam int IMG_H      = 6;
    localparam int IMG_PIXELS = IMG_W * IMG_H;
    localparam int OUT_W      = IMG_W - 2;
    localparam int FRAME      = OUT_W * (IMG_H - 2);  // Filtered pixels per frame
    localparam int THRESHOLD  = 128;
    localparam int MIN_AREA   = 4;
    localparam int MAX_AREA   = 20;
    localparam int MIN_SEGS   = 2;
    localparam int TIMEOUT    = 1000;                  // Cycles allowed per wait
    localparam int N_TESTS    = 6;

    // Kernel selectors
    localparam int K_IDENT   = 0;
    localparam int K_LAPLACE = 1;
    localparam int K_HEDGE   = 2;

    // Image patterns
    localparam int P_FLAT     = 0;
    localparam int P_BAR      = 1;
    localparam int P_TWO_BARS = 2;
    localparam int P_RANDOM   = 3;

    // Taps in raster order starting at the window's top-left
    int kernel_taps [0:2][0:8] = '{
        '{ 0,  0,  0,  0, 1,  0, 0,  0, 0},   // Identity centre
        '{ 0, -1,  0, -1, 4, -1, 0, -1, 0},   // Laplacian
        '{-1, -2, -1,  0, 0,  0, 1,  2, 1}    // Horizontal edge
    };

    // Columns are kernel, image, y_ready stall mode and expected crossing
    int test_table [0:N_TESTS-1][0:3] = '{
        '{K_IDENT,   P_FLAT,     0, 0},   // 24 whites is above the area limit
        '{K_IDENT,   P_BAR,      0, 1},   // One white column gives 4 runs
        '{K_LAPLACE, P_TWO_BARS, 0, 1},   // Bars clamp to 255 and sides to 0
        '{K_HEDGE,   P_BAR,      1, 0},   // No vertical change leaves all black
        '{K_IDENT,   P_TWO_BARS, 1, 1},
        '{K_LAPLACE, P_RANDOM,   1, 0}    // Low noise never reaches white
    };

    logic                           clk_video = 1'b0;
    logic                           rst_n;
    logic                           x_valid;
    logic                           x_ready;
    video_pkg::pixel_t              x_data;
    video_pkg::coef_t               kernel [0:2][0:2];
    logic                           y_valid;
    logic                           y_ready;
    video_pkg::pixel_t              y_data;
    logic                           capture_trigger;
    logic                           capture_complete;
    logic                           capturing;
    logic                           crossing_detected;
    logic                           detection_valid;
    logic [detect_pkg::COUNT_W-1:0] white_count;
    logic [detect_pkg::SEG_W-1:0]   segment_count;

    int     img       [0:IMG_PIXELS-1];
    int     model_pix [0:FRAME-1];   // Expected filtered frame
    int     exp_white;
    int     exp_segs;
    integer seed = 32'h14f2e018;

    pattern_recognition pattern_recognition_i (.*);

    initial begin
        forever #20 clk_video = ~clk_video;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d",
                               $time, name, got, want));
        end
    endtask

    task automatic build_image(input int pattern);
        int v;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                case (pattern)
                    P_FLAT:     v = 200;
                    P_BAR:      v = (c == 3) ? 255 : 0;
                    P_TWO_BARS: v = (c == 2 || c == 5) ? 255 : 0;
                    default:    v = $random(seed) & 31;  // Laplacian peak 124
                endcase
                img[r*IMG_W + c] = v;
            end
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    task automatic run_model(input int sel);
        int sum;
        int white;
        int prev_white;
        exp_white = 0;
        exp_segs  = 0;
        for (int r = 0; r < IMG_H - 2; r++) begin
            prev_white = 0;                      // Runs never span rows
            for (int c = 0; c < OUT_W; c++) begin
                sum = 0;
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        sum += kernel_taps[sel][i*3 + j] * img[(r+i)*IMG_W + c + j];
                    end
                end
                sum = (sum < 0) ? 0 : ((sum > 255) ? 255 : sum);
                model_pix[r*OUT_W + c] = sum;
                white = (sum >= THRESHOLD) ? 1 : 0;
                exp_white += white;
                if (white == 1 && prev_white == 0) exp_segs++;  // Run starts
                prev_white = white;
            end
        end
    endtask

    task automatic run_frame(input int t);
        int in_idx;
        int out_idx;
        int cycles;
        int completes;
        int detections;
        int hold;
        int held_data;
        int rule;
        int retriggered;
        in_idx      = 0;
        out_idx     = 0;
        hold        = 0;
        retriggered = 0;
        // Kernel changes only while the filter is idle
        @(negedge clk_video);
        for (int i = 0; i < 9; i++) begin
            kernel[i/3][i%3] = video_pkg::coef_t'(kernel_taps[test_table[t][0]][i]);
        end
        capture_trigger = 1'b1;
        #1;
        check_value("capturing", capturing, 0);
        @(negedge clk_video);
        capture_trigger = 1'b0;
        #1;
        check_value("capturing", capturing, 1);

        // ========================================
        // Stream one frame through the filter
        // ========================================
        cycles = 0;
        while (out_idx < FRAME) begin
            @(negedge clk_video);
            if (in_idx < IMG_PIXELS) begin
                x_valid = 1'b1;
                x_data  = video_pkg::pixel_t'(img[in_idx]);
            end else begin
                x_valid = 1'b0;
            end
            y_ready = (test_table[t][2] == 0) || (($random(seed) & 1) != 0);
            // Retrigger once while armed with half the frame written
            capture_trigger = (out_idx == FRAME / 2) && (retriggered == 0);
            if (capture_trigger) retriggered = 1;
            #1;
            if (hold != 0) begin                // Output must wait unchanged
                check_value("y_valid", y_valid, 1);
                check_value("y_data", y_data, held_data);
            end
            hold      = (y_valid && !y_ready) ? 1 : 0;
            held_data = y_data;
            if (x_valid && x_ready) in_idx++;
            if (y_valid && y_ready) begin
                check_value($sformatf("y_data[%0d]", out_idx), y_data, model_pix[out_idx]);
                out_idx++;
            end
            check_value("capturing", capturing, 1);
            check_value("capture_complete", capture_complete, 0);
            cycles++;
            if (cycles > TIMEOUT) fail_run("Timeout: the filtered frame did not complete");
        end
        check_value("input pixels accepted", in_idx, IMG_PIXELS);

        // Wait for the analyzer with no further output allowed
        completes  = 0;
        detections = 0;
        cycles     = 0;
        while (detections == 0) begin
            @(negedge clk_video);
            x_valid         = 1'b0;
            y_ready         = 1'b1;
            capture_trigger = 1'b0;
            #1;
            check_value("y_valid", y_valid, 0);
            if (capture_complete) begin
                completes++;
                check_value("capturing", capturing, 0);  // Falls with the pulse
            end
            if (detection_valid) detections++;
            cycles++;
            if (cycles > TIMEOUT) fail_run("Timeout: detection_valid never pulsed after capture");
        end
        rule = (exp_white >= MIN_AREA && exp_white <= MAX_AREA && exp_segs >= MIN_SEGS);
        check_value("table crossing flag", test_table[t][3], rule);
        check_value("white_count", white_count, exp_white);
        check_value("segment_count", segment_count, exp_segs);
        check_value("crossing_detected", crossing_detected, test_table[t][3]);
        repeat (4) begin                        // Catch repeated pulses
            @(negedge clk_video);
            #1;
            completes  += capture_complete;
            detections += detection_valid;
        end
        check_value("capture_complete pulses", completes, 1);
        check_value("detection_valid pulses", detections, 1);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rst_n           = 1'b0;
        x_valid         = 1'b0;
        x_data          = '0;
        y_ready         = 1'b0;
        capture_trigger = 1'b0;
        for (int i = 0; i < 9; i++) kernel[i/3][i%3] = '0;
        repeat (16) @(negedge clk_video);
        #1;
        check_value("x_ready", x_ready, 0);
        check_value("y_valid", y_valid, 0);
        check_value("capturing", capturing, 0);
        check_value("capture_complete", capture_complete, 0);
        check_value("detection_valid", detection_valid, 0);
        check_value("crossing_detected", crossing_detected, 0);
        check_value("white_count", white_count, 0);
        check_value("segment_count", segment_count, 0);
        rst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            build_image(test_table[t][1]);
            run_model(test_table[t][0]);
            run_frame(t);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
